/* i3c_standby_params.svh */
// Timer width, synchronizer depth and Target Reset Pattern length macros

`ifndef I3C_STANDBY_PARAMS_SVH
`define I3C_STANDBY_PARAMS_SVH

// Bus condition counter and threshold width
`define I3C_TIMER_W 20

// Flops per pin in the SCL/SDA synchronizers
`define I3C_SYNC_STAGES 2

// SDA transitions with SCL low that open a Target Reset Pattern
`define I3C_RST_PATTERN_EDGES 14

`endif

/* i3c_standby_pkg.sv */
// Reset action codes and Target Reset Pattern detector states

`default_nettype none

package i3c_standby_pkg;

  // Defining byte of the RSTACT CCC
  typedef enum logic [7:0] {
    RstActNone   = 8'h00,
    RstActPeriph = 8'h01,
    RstActWhole  = 8'h02
  } rst_action_e;

  // Target Reset Pattern recognition
  typedef enum logic [1:0] {
    RpIdle,
    RpCount,
    RpWaitSr,
    RpWaitStop
  } rst_pat_state_e;

endpackage

`default_nettype wire

/* bus_edge_detect.sv */
// SCL/SDA synchronizers with edge, START and STOP strobe generation

`timescale 1ns/1ps
`default_nettype none
`include "i3c_standby_params.svh"

module bus_edge_detect (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_high_o,
  output logic scl_posedge_o,
  output logic scl_negedge_o,
  output logic sda_posedge_o,
  output logic sda_negedge_o,
  output logic start_det_o,
  output logic stop_det_o
);

  localparam int unsigned SyncStages = `I3C_SYNC_STAGES;

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic scl_s;
  logic sda_s;
  logic scl_q;
  logic sda_q;
  logic scl_rise;
  logic scl_fall;
  logic sda_rise;
  logic sda_fall;

  // Open-drain bus idles high, so no false edge out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_q      <= scl_s;
      sda_q      <= sda_s;
    end
  end

  assign scl_s = scl_sync_q[SyncStages-1];
  assign sda_s = sda_sync_q[SyncStages-1];

  assign scl_rise = scl_s & ~scl_q;
  assign scl_fall = ~scl_s & scl_q;
  assign sda_rise = sda_s & ~sda_q;
  assign sda_fall = ~sda_s & sda_q;

  // Strobes line up with the history flop, so scl_high_o matches them
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_posedge_o <= 1'b0;
      scl_negedge_o <= 1'b0;
      sda_posedge_o <= 1'b0;
      sda_negedge_o <= 1'b0;
      start_det_o   <= 1'b0;
      stop_det_o    <= 1'b0;
    end else begin
      scl_posedge_o <= enable_i & scl_rise;
      scl_negedge_o <= enable_i & scl_fall;
      sda_posedge_o <= enable_i & sda_rise;
      sda_negedge_o <= enable_i & sda_fall;
      start_det_o   <= enable_i & sda_fall & scl_q;
      stop_det_o    <= enable_i & sda_rise & scl_q;
    end
  end

  assign scl_high_o = scl_q;

  a_start_stop_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(start_det_o && stop_det_o));

endmodule

`default_nettype wire

/* bus_timers.sv */
// Bus busy flag and free, available and idle condition timers

`timescale 1ns/1ps
`default_nettype none
`include "i3c_standby_params.svh"

module bus_timers (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic                    start_det_i,
  input  logic                    stop_det_i,
  input  logic [`I3C_TIMER_W-1:0] t_bus_free_i,
  input  logic [`I3C_TIMER_W-1:0] t_bus_available_i,
  input  logic [`I3C_TIMER_W-1:0] t_bus_idle_i,
  output logic                    bus_busy_o,
  output logic                    bus_free_o,
  output logic                    bus_available_o,
  output logic                    bus_idle_o
);

  localparam int unsigned TimerW = `I3C_TIMER_W;

  logic [TimerW-1:0] cnt_q;
  logic [TimerW-1:0] cnt_d;
  logic busy_d;
  logic free_d;
  logic available_d;
  logic idle_d;

  // Cycles since the last STOP, saturating
  always_comb begin
    if (stop_det_i) begin
      cnt_d = '0;
    end else if (&cnt_q) begin
      cnt_d = cnt_q;
    end else begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  always_comb begin
    busy_d = bus_busy_o;
    if (!enable_i) begin
      busy_d = 1'b0;
    end else if (start_det_i) begin
      busy_d = 1'b1;
    end else if (stop_det_i) begin
      busy_d = 1'b0;
    end
  end

  // Compare against next busy so levels drop together with the rise of busy
  assign free_d      = enable_i & ~busy_d & (cnt_d >= t_bus_free_i);
  assign available_d = enable_i & ~busy_d & (cnt_d >= t_bus_available_i);
  assign idle_d      = enable_i & ~busy_d & (cnt_d >= t_bus_idle_i);

  // Counter starts saturated so the bus reads free after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q           <= '1;
      bus_busy_o      <= 1'b0;
      bus_free_o      <= 1'b0;
      bus_available_o <= 1'b0;
      bus_idle_o      <= 1'b0;
    end else begin
      cnt_q           <= cnt_d;
      bus_busy_o      <= busy_d;
      bus_free_o      <= free_d;
      bus_available_o <= available_d;
      bus_idle_o      <= idle_d;
    end
  end

  a_busy_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_busy_o |-> !(bus_free_o || bus_available_o || bus_idle_o));

endmodule

`default_nettype wire

/* target_reset_detector.sv */
// Target Reset Pattern recognizer driven by bus edge strobes

`timescale 1ns/1ps
`default_nettype none
`include "i3c_standby_params.svh"

module target_reset_detector
  import i3c_standby_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_high_i,
  input  logic sda_posedge_i,
  input  logic sda_negedge_i,
  input  logic start_det_i,
  input  logic stop_det_i,
  output logic target_reset_det_o
);

  localparam int unsigned PatEdges = `I3C_RST_PATTERN_EDGES;
  localparam int unsigned CntW = $clog2(PatEdges + 1);

  rst_pat_state_e state_q;
  rst_pat_state_e state_d;
  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;
  logic det_d;
  logic sda_edge;
  logic low_edge;

  assign sda_edge = sda_posedge_i | sda_negedge_i;
  assign low_edge = sda_edge & ~scl_high_i;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    det_d   = 1'b0;
    unique case (state_q)
      RpIdle: begin
        if (low_edge) begin
          state_d = RpCount;
          cnt_d   = CntW'(1);
        end
      end
      RpCount: begin
        // SCL released before the full toggle count
        if (scl_high_i) begin
          state_d = RpIdle;
        end else if (low_edge) begin
          cnt_d = cnt_q + 1'b1;
          if (cnt_q == CntW'(PatEdges - 1)) begin
            state_d = RpWaitSr;
          end
        end
      end
      RpWaitSr: begin
        if (start_det_i) begin
          state_d = RpWaitStop;
        end else if (sda_edge) begin
          state_d = RpIdle;
        end
      end
      RpWaitStop: begin
        if (stop_det_i) begin
          state_d = RpIdle;
          det_d   = 1'b1;
        end else if (sda_edge) begin
          state_d = RpIdle;
        end
      end
      default: begin
        state_d = RpIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q            <= RpIdle;
      cnt_q              <= '0;
      target_reset_det_o <= 1'b0;
    end else begin
      state_q            <= state_d;
      cnt_q              <= cnt_d;
      target_reset_det_o <= det_d;
    end
  end

  a_det_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    target_reset_det_o |=> !target_reset_det_o);

endmodule

`default_nettype wire

/* reset_action_ctrl.sv */
// Peripheral and escalated reset control from patterns and RSTACT codes

`timescale 1ns/1ps
`default_nettype none

module reset_action_ctrl
  import i3c_standby_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        target_reset_det_i,
  input  logic        start_det_i,
  input  rst_action_e rst_action_i,
  input  logic        rst_action_valid_i,
  input  logic        peripheral_reset_done_i,
  output logic        peripheral_reset_o,
  output logic        escalated_reset_o
);

  logic armed_q;
  logic escalate_q;
  logic start_pend_q;
  logic act_periph;
  logic act_whole;
  logic act_none;
  logic pattern_hit;
  logic periph_set;
  logic escal_set;
  logic escalate_clr;

  assign act_periph = rst_action_valid_i & (rst_action_i == RstActPeriph);
  assign act_whole  = rst_action_valid_i & (rst_action_i == RstActWhole);
  assign act_none   = rst_action_valid_i & (rst_action_i == RstActNone);

  // An armed RSTACT swallows the next pattern
  assign pattern_hit = target_reset_det_i & ~armed_q;

  assign periph_set = act_periph | (pattern_hit & ~escalate_q);
  assign escal_set  = act_whole | (pattern_hit & escalate_q);

  // The Sr inside a pattern is consumed by the pattern pulse, so only a
  // START that finds an earlier unconsumed START is an ordinary one
  assign escalate_clr = start_det_i & start_pend_q & ~peripheral_reset_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q      <= 1'b0;
      escalate_q   <= 1'b0;
      start_pend_q <= 1'b0;
    end else begin
      if (act_periph || act_whole) begin
        armed_q <= 1'b0;
      end else if (act_none) begin
        armed_q <= 1'b1;
      end else if (target_reset_det_i) begin
        armed_q <= 1'b0;
      end

      if (pattern_hit && !escalate_q) begin
        escalate_q <= 1'b1;
      end else if (escalate_clr) begin
        escalate_q <= 1'b0;
      end

      if (target_reset_det_i) begin
        start_pend_q <= 1'b0;
      end else if (start_det_i) begin
        start_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      peripheral_reset_o <= 1'b0;
      escalated_reset_o  <= 1'b0;
    end else begin
      if (periph_set) begin
        peripheral_reset_o <= 1'b1;
      end else if (peripheral_reset_done_i) begin
        peripheral_reset_o <= 1'b0;
      end
      // Held until the next rst_ni
      if (escal_set) begin
        escalated_reset_o <= 1'b1;
      end
    end
  end

  a_escal_sticky : assert property (@(posedge clk_i) disable iff (!rst_ni)
    escalated_reset_o |=> escalated_reset_o);

endmodule

`default_nettype wire

/* i3c_standby_top.sv */
// Standby target bus-condition and reset-handling top level

`timescale 1ns/1ps
`default_nettype none
`include "i3c_standby_params.svh"

module i3c_standby_top
  import i3c_standby_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic                    scl_i,
  input  logic                    sda_i,
  input  logic [`I3C_TIMER_W-1:0] t_bus_free_i,
  input  logic [`I3C_TIMER_W-1:0] t_bus_available_i,
  input  logic [`I3C_TIMER_W-1:0] t_bus_idle_i,
  input  rst_action_e             rst_action_i,
  input  logic                    rst_action_valid_i,
  input  logic                    peripheral_reset_done_i,
  output logic                    bus_busy_o,
  output logic                    bus_free_o,
  output logic                    bus_available_o,
  output logic                    bus_idle_o,
  output logic                    peripheral_reset_o,
  output logic                    escalated_reset_o
);

  logic scl_high;
  logic sda_posedge;
  logic sda_negedge;
  logic start_det;
  logic stop_det;
  logic target_reset_det;

  // SCL edge strobes have no consumer among the bus-condition blocks
  bus_edge_detect u_bus_edge_detect (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (enable_i),
    .scl_i         (scl_i),
    .sda_i         (sda_i),
    .scl_high_o    (scl_high),
    .scl_posedge_o (),
    .scl_negedge_o (),
    .sda_posedge_o (sda_posedge),
    .sda_negedge_o (sda_negedge),
    .start_det_o   (start_det),
    .stop_det_o    (stop_det)
  );

  bus_timers u_bus_timers (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .enable_i          (enable_i),
    .start_det_i       (start_det),
    .stop_det_i        (stop_det),
    .t_bus_free_i      (t_bus_free_i),
    .t_bus_available_i (t_bus_available_i),
    .t_bus_idle_i      (t_bus_idle_i),
    .bus_busy_o        (bus_busy_o),
    .bus_free_o        (bus_free_o),
    .bus_available_o   (bus_available_o),
    .bus_idle_o        (bus_idle_o)
  );

  target_reset_detector u_target_reset_detector (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .scl_high_i         (scl_high),
    .sda_posedge_i      (sda_posedge),
    .sda_negedge_i      (sda_negedge),
    .start_det_i        (start_det),
    .stop_det_i         (stop_det),
    .target_reset_det_o (target_reset_det)
  );

  reset_action_ctrl u_reset_action_ctrl (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .target_reset_det_i      (target_reset_det),
    .start_det_i             (start_det),
    .rst_action_i            (rst_action_i),
    .rst_action_valid_i      (rst_action_valid_i),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .peripheral_reset_o      (peripheral_reset_o),
    .escalated_reset_o       (escalated_reset_o)
  );

endmodule

`default_nettype wire

/* tb_i3c_standby.sv */
// Testbench for the I3C standby bus-condition and reset-handling top level

`timescale 1ns/1ps
`default_nettype none
`include "i3c_standby_params.svh"

module tb_i3c_standby
  import i3c_standby_pkg::*;
();

  localparam int TimerW = `I3C_TIMER_W;
  localparam int PatEdges = `I3C_RST_PATTERN_EDGES;
  // Pin change to strobe, synchronizer plus history flop
  localparam int PinLat = `I3C_SYNC_STAGES + 1;
  // Cycles each pin level is held
  localparam int HoldCycles = 4;

  localparam int SigBusy = 0;
  localparam int SigIdle = 1;
  localparam int SigPeriph = 2;
  localparam int SigEscal = 3;

  logic clk_i;
  logic rst_ni;
  logic enable_i;
  logic scl_i;
  logic sda_i;
  logic [TimerW-1:0] t_bus_free_i;
  logic [TimerW-1:0] t_bus_available_i;
  logic [TimerW-1:0] t_bus_idle_i;
  rst_action_e rst_action_i;
  logic rst_action_valid_i;
  logic peripheral_reset_done_i;
  logic bus_busy_o;
  logic bus_free_o;
  logic bus_available_o;
  logic bus_idle_o;
  logic peripheral_reset_o;
  logic escalated_reset_o;

  // Expectations armed by the stimulus and checked every cycle
  logic expect_quiet;
  logic expect_periph;
  logic expect_escal;
  logic [31:0] lcg_state;

  i3c_standby_top uut (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .enable_i                (enable_i),
    .scl_i                   (scl_i),
    .sda_i                   (sda_i),
    .t_bus_free_i            (t_bus_free_i),
    .t_bus_available_i       (t_bus_available_i),
    .t_bus_idle_i            (t_bus_idle_i),
    .rst_action_i            (rst_action_i),
    .rst_action_valid_i      (rst_action_valid_i),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .bus_busy_o              (bus_busy_o),
    .bus_free_o              (bus_free_o),
    .bus_available_o         (bus_available_o),
    .bus_idle_o              (bus_idle_o),
    .peripheral_reset_o      (peripheral_reset_o),
    .escalated_reset_o       (escalated_reset_o)
  );

  always #20 clk_i = ~clk_i;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  a_level_order : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bus_idle_o && !bus_available_o) && !(bus_available_o && !bus_free_o))
    else fail_now($sformatf(
      "CHECK FAILED bus_idle_o/bus_available_o/bus_free_o got 0x%h/0x%h/0x%h",
      $sampled(bus_idle_o), $sampled(bus_available_o), $sampled(bus_free_o)));

  a_quiet : assert property (@(posedge clk_i) disable iff (!rst_ni)
    expect_quiet |-> (!peripheral_reset_o && !escalated_reset_o))
    else fail_now($sformatf(
      "CHECK FAILED peripheral_reset_o/escalated_reset_o got 0x%h/0x%h expected 0x0/0x0",
      $sampled(peripheral_reset_o), $sampled(escalated_reset_o)));

  a_periph_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    expect_periph |-> peripheral_reset_o)
    else fail_now("CHECK FAILED peripheral_reset_o got 0x0 expected 0x1");

  a_escal_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    expect_escal |-> escalated_reset_o)
    else fail_now("CHECK FAILED escalated_reset_o got 0x0 expected 0x1");

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else fail_now($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_range(input string name, input logic [31:0] got,
                             input logic [31:0] lo, input logic [31:0] hi);
    assert (got >= lo && got <= hi)
      else fail_now($sformatf("CHECK FAILED %s got 0x%h expected 0x%h to 0x%h",
                              name, got, lo, hi));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
    logic [31:0] r;
    r = lcg_next();
    return lo + ((r >> 8) % (hi - lo + 1));
  endfunction

  function automatic logic sig_level(input int sel);
    case (sel)
      SigBusy:   return bus_busy_o;
      SigIdle:   return bus_idle_o;
      SigPeriph: return peripheral_reset_o;
      default:   return escalated_reset_o;
    endcase
  endfunction

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic hold(input int n);
    repeat (n) step();
  endtask

  // Current level counts, then at most max_cycles more clocks
  task automatic wait_level(input int sel, input logic level, input int max_cycles,
                            input string name);
    int n;
    n = 0;
    while (sig_level(sel) !== level) begin
      if (n >= max_cycles) begin
        fail_now($sformatf("timeout waiting for %s to go to %0d", name, level));
      end else begin
        step();
        n++;
      end
    end
  endtask

  task automatic pick_thresholds();
    int unsigned a;
    int unsigned b;
    int unsigned c;
    int unsigned tmp;
    a = rand_range(4, 40);
    b = rand_range(4, 40);
    c = rand_range(4, 40);
    if (a > b) begin
      tmp = a;
      a = b;
      b = tmp;
    end
    if (b > c) begin
      tmp = b;
      b = c;
      c = tmp;
    end
    if (a > b) begin
      tmp = a;
      a = b;
      b = tmp;
    end
    t_bus_free_i = TimerW'(a);
    t_bus_available_i = TimerW'(b);
    t_bus_idle_i = TimerW'(c);
  endtask

  task automatic apply_reset();
    expect_quiet = 1'b0;
    expect_periph = 1'b0;
    expect_escal = 1'b0;
    scl_i = 1'b1;
    sda_i = 1'b1;
    rst_action_i = RstActNone;
    rst_action_valid_i = 1'b0;
    peripheral_reset_done_i = 1'b0;
    rst_ni = 1'b0;
    hold(2);
    rst_ni = 1'b1;
    hold(2);
  endtask

  // From an idle bus, ends with SCL low
  task automatic bus_start();
    sda_i = 1'b0;
    hold(HoldCycles);
    scl_i = 1'b0;
    hold(HoldCycles);
  endtask

  // From SCL low, ends right after the SDA rise
  task automatic bus_stop();
    sda_i = 1'b0;
    hold(HoldCycles);
    scl_i = 1'b1;
    hold(HoldCycles);
    sda_i = 1'b1;
  endtask

  task automatic repeated_start();
    sda_i = 1'b1;
    hold(HoldCycles);
    scl_i = 1'b1;
    hold(HoldCycles);
    sda_i = 1'b0;
    hold(HoldCycles);
    scl_i = 1'b0;
    hold(HoldCycles);
  endtask

  task automatic toggle_sda(input int count);
    repeat (count) begin
      sda_i = ~sda_i;
      hold(HoldCycles);
    end
  endtask

  task automatic reset_pattern();
    scl_i = 1'b0;
    hold(HoldCycles);
    toggle_sda(PatEdges);
    repeated_start();
    bus_stop();
  endtask

  // Cycle of first high level, counted from the STOP's SDA rise
  task automatic measure_levels();
    int k;
    int free_k;
    int avail_k;
    int idle_k;
    k = 0;
    free_k = 0;
    avail_k = 0;
    idle_k = 0;
    while (free_k == 0 || avail_k == 0 || idle_k == 0) begin
      if (k > int'(t_bus_idle_i) + 10) begin
        fail_now("timeout waiting for the bus levels to rise after a STOP");
      end else begin
        step();
        k++;
        if (bus_free_o && free_k == 0) free_k = k;
        if (bus_available_o && avail_k == 0) avail_k = k;
        if (bus_idle_o && idle_k == 0) idle_k = k;
      end
    end
    check_range("bus_free_o rise cycle", free_k, t_bus_free_i + PinLat, t_bus_free_i + 6);
    check_range("bus_available_o rise cycle", avail_k, t_bus_available_i + PinLat,
                t_bus_available_i + 6);
    check_range("bus_idle_o rise cycle", idle_k, t_bus_idle_i + PinLat, t_bus_idle_i + 6);
    check_eq("bus_busy_o", bus_busy_o, 0);
  endtask

  task automatic start_stop_burst();
    bus_start();
    wait_level(SigBusy, 1'b1, HoldCycles, "bus_busy_o");
    check_eq("bus_free_o", bus_free_o, 0);
    check_eq("bus_available_o", bus_available_o, 0);
    check_eq("bus_idle_o", bus_idle_o, 0);
    pick_thresholds();
    hold(rand_range(1, 20));
    bus_stop();
    measure_levels();
    hold(rand_range(1, 20));
  endtask

  initial begin
    clk_i = 1'b0;
    enable_i = 1'b1;
    lcg_state = 32'he1e0;
    pick_thresholds();
    apply_reset();

    // Bus conditions around START and STOP
    wait_level(SigIdle, 1'b1, 60, "bus_idle_o");
    repeat (3) start_stop_burst();

    // Thirteen toggles, then SCL released
    apply_reset();
    expect_quiet = 1'b1;
    scl_i = 1'b0;
    hold(HoldCycles);
    toggle_sda(PatEdges - 1);
    scl_i = 1'b1;
    hold(HoldCycles);
    // Count starts over, so one more toggle with Sr and STOP is no pattern
    scl_i = 1'b0;
    hold(HoldCycles);
    toggle_sda(1);
    repeated_start();
    bus_stop();
    hold(4 * PinLat);

    // Full toggle count but STOP without repeated START
    apply_reset();
    expect_quiet = 1'b1;
    scl_i = 1'b0;
    hold(HoldCycles);
    toggle_sda(PatEdges);
    bus_stop();
    hold(4 * PinLat);

    // RSTACT strobes
    apply_reset();
    rst_action_i = RstActPeriph;
    rst_action_valid_i = 1'b1;
    step();
    rst_action_valid_i = 1'b0;
    wait_level(SigPeriph, 1'b1, 1, "peripheral_reset_o");
    check_eq("escalated_reset_o", escalated_reset_o, 0);
    apply_reset();
    rst_action_i = RstActWhole;
    rst_action_valid_i = 1'b1;
    step();
    rst_action_valid_i = 1'b0;
    wait_level(SigEscal, 1'b1, 1, "escalated_reset_o");
    apply_reset();
    rst_action_i = RstActNone;
    rst_action_valid_i = 1'b1;
    step();
    rst_action_valid_i = 1'b0;
    expect_quiet = 1'b1;
    reset_pattern();
    hold(4 * PinLat);

    // First pattern gives a peripheral reset
    apply_reset();
    reset_pattern();
    wait_level(SigPeriph, 1'b1, PinLat + 3, "peripheral_reset_o");
    expect_periph = 1'b1;
    check_eq("escalated_reset_o", escalated_reset_o, 0);
    hold(rand_range(2, 20));
    expect_periph = 1'b0;
    peripheral_reset_done_i = 1'b1;
    step();
    peripheral_reset_done_i = 1'b0;
    wait_level(SigPeriph, 1'b0, 2, "peripheral_reset_o");
    check_eq("escalated_reset_o", escalated_reset_o, 0);

    // Second pattern escalates, held through later traffic
    hold(rand_range(4, 20));
    reset_pattern();
    wait_level(SigEscal, 1'b1, PinLat + 3, "escalated_reset_o");
    expect_escal = 1'b1;
    check_eq("peripheral_reset_o", peripheral_reset_o, 0);
    hold(rand_range(4, 20));
    start_stop_burst();

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
i3c_standby_pkg.sv
bus_edge_detect.sv
bus_timers.sv
target_reset_detector.sv
reset_action_ctrl.sv
i3c_standby_top.sv
tb_i3c_standby.sv

/* run.sh */
#!/bin/sh
# Build and run the I3C standby testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_i3c_standby -f files.f
./obj_dir/Vtb_i3c_standby > sim.log 2>&1 || true
cat sim.log
if grep -q "^TEST PASSED$" sim.log; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi
